//--- logic/cart_params.svh
//////////////////////////////////////////////////
// Header addresses, bus widths and backup size
// Include in any module that decodes the download
//////////////////////////////////////////////////
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// Download bus
`define CART_DL_ADDR_W     25

// Region letters in the ROM header
`define CART_HDR_REGION_A  'h1F0
`define CART_HDR_REGION_B  'h1F2
`define CART_HDR_END       'h200    // First word past the header

// Serial number field
`define CART_ID_FIRST      'h182
`define CART_ID_DECIDE     'h18C    // Lookup happens on this write

// Backup RAM image
`define BK_SECTORS_LOG2    7        // 128 sectors
`define SD_LBA_W           32

`endif

//--- logic/cart_pkg.sv
//////////////////////////////////////////////////
// Types shared by the cartridge-load blocks
// Import where download words or regions are decoded
//////////////////////////////////////////////////
package cart_pkg;

	// One download word, used whole or split into bytes
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} dl_word_u;

	// Console region as seen by the status bits
	typedef enum logic [1:0] {
		REG_JP = 2'd0,
		REG_US = 2'd1,
		REG_EU = 2'd2
	} region_e;

endpackage

//--- logic/cart_region_scan.sv
//////////////////////////////////////////////////
// Picks region letters out of the ROM header
// Flags stay valid until the next download starts
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cart_params.svh"

module cart_region_scan (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  logic [`CART_DL_ADDR_W-1:0] dl_addr,
	input  cart_pkg::dl_word_u         dl_data,
	output logic                       hdr_j,
	output logic                       hdr_u,
	output logic                       hdr_e,
	output logic                       hdr_ready
);
	localparam logic [`CART_DL_ADDR_W-1:0] REGION_A = `CART_HDR_REGION_A;
	localparam logic [`CART_DL_ADDR_W-1:0] REGION_B = `CART_HDR_REGION_B;
	localparam logic [`CART_DL_ADDR_W-1:0] HDR_END  = `CART_HDR_END;

	logic       dl_active_d;
	logic [2:0] lo_hit;
	logic [2:0] hi_hit;
	wire        hdr_wr = dl_active & dl_wr;

	// {J, U, other} for one header character
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		if (c == "J")
			return 3'b100;
		else if (c == "U")
			return 3'b010;
		else if (c >= "0" && c <= "Z")
			return 3'b001;   // Any other code counts as EU
		return 3'b000;
	endfunction

	always_comb begin
		lo_hit = '0;
		hi_hit = '0;
		if (dl_addr == REGION_A || dl_addr == REGION_B)
			lo_hit = letter_flags(dl_data.bytes.lo);
		if (dl_addr == REGION_A)
			hi_hit = letter_flags(dl_data.bytes.hi);   // Only the first word has two
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_d <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active & ~dl_active_d)
				{hdr_j, hdr_u, hdr_e} <= '0;
			if (~dl_active & dl_active_d)
				hdr_ready <= 1'b0;
			if (hdr_wr) begin
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | lo_hit | hi_hit;
				if (dl_addr == HDR_END)
					hdr_ready <= 1'b1;
			end
		end
	end

	// Ready must not outlive the download by more than a cycle
	a_ready_drops: assert property (@(posedge clk_sys) disable iff (RESET)
		(!dl_active && !$past(dl_active)) |-> !hdr_ready);

endmodule

//--- logic/cart_quirk_table.sv
//////////////////////////////////////////////////
// Captures the cartridge serial and flags quirks
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cart_params.svh"

module cart_quirk_table (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  logic [`CART_DL_ADDR_W-1:0] dl_addr,
	input  cart_pkg::dl_word_u         dl_data,
	output logic                       sram_quirk,
	output logic                       eeprom_quirk,
	output logic                       svp_quirk,
	output logic                       fmbusy_quirk
);
	localparam logic [`CART_DL_ADDR_W-1:0] ID_FIRST  = `CART_ID_FIRST;
	localparam logic [`CART_DL_ADDR_W-1:0] ID_DECIDE = `CART_ID_DECIDE;

	logic        dl_active_d;
	logic [63:0] cart_id;   // ASCII, first character in the top byte
	wire         hdr_wr = dl_active & dl_wr;

	// Bytes within each word come in swapped
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (dl_addr)
				ID_FIRST:         cart_id[63:56] <= dl_data.bytes.hi;
				ID_FIRST + 2'd2:  cart_id[55:40] <= {dl_data.bytes.lo, dl_data.bytes.hi};
				ID_FIRST + 3'd4:  cart_id[39:24] <= {dl_data.bytes.lo, dl_data.bytes.hi};
				ID_FIRST + 3'd6:  cart_id[23:8]  <= {dl_data.bytes.lo, dl_data.bytes.hi};
				ID_FIRST + 4'd8:  cart_id[7:0]   <= dl_data.bytes.lo;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_d <= 1'b0;
			{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= '0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active & ~dl_active_d)
				{sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk} <= '0;   // New image
			if (hdr_wr && dl_addr == ID_DECIDE) begin
				if (cart_id == "T-081276" || cart_id == "T-81406 ")
					sram_quirk <= 1'b1;     // SRAM left mapped over ROM
				else if (cart_id == "MK-1215 " || cart_id == "G-4060  ")
					eeprom_quirk <= 1'b1;
				else if (cart_id == "MK-1229 " || cart_id == "G-7001  ")
					svp_quirk <= 1'b1;      // DSP cart, no backup RAM
				else if (cart_id == "T-35036 ")
					fmbusy_quirk <= 1'b1;
			end
		end
	end

	a_one_quirk: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0({sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk}));

endmodule

//--- logic/region_select.sv
//////////////////////////////////////////////////
// Region request from header letters or file index
//////////////////////////////////////////////////
`timescale 1ns/10ps

module region_select (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              hdr_j,
	input  logic              hdr_u,
	input  logic              hdr_e,
	input  logic              hdr_ready,
	input  logic              reg_auto_off,
	input  logic              reg_from_hdr,
	input  logic [1:0]        reg_prio,
	input  logic [7:0]        dl_index,
	output cart_pkg::region_e region_req,
	output logic              region_set
);
	import cart_pkg::*;

	logic    hdr_ready_d;
	region_e hdr_pick;

	// First letter found in priority order, else the first region
	always_comb begin
		case (reg_prio)
			2'd0:    hdr_pick = hdr_u ? REG_US : hdr_e ? REG_EU : hdr_j ? REG_JP : REG_US;
			2'd1:    hdr_pick = hdr_e ? REG_EU : hdr_u ? REG_US : hdr_j ? REG_JP : REG_EU;
			2'd2:    hdr_pick = hdr_u ? REG_US : hdr_j ? REG_JP : hdr_e ? REG_EU : REG_US;
			default: hdr_pick = hdr_j ? REG_JP : hdr_u ? REG_US : hdr_e ? REG_EU : REG_JP;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_ready_d <= 1'b0;
			region_req  <= REG_JP;
			region_set  <= 1'b0;
		end else begin
			hdr_ready_d <= hdr_ready;
			if (~reg_auto_off & hdr_ready & ~hdr_ready_d) begin
				if (reg_from_hdr) begin
					region_req <= hdr_pick;
					region_set <= 1'b1;
				end else begin
					region_req <= region_e'(dl_index[7:6]);   // Index encodes the region
					region_set <= |dl_index;
				end
			end
			if (~hdr_ready & hdr_ready_d)
				region_set <= 1'b0;
		end
	end

endmodule

//--- logic/bram_sector_count.sv
//////////////////////////////////////////////////
// Backup RAM sector address for the host requests
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cart_params.svh"

module bram_sector_count (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cnt_clear,
	input  logic                 cnt_step,
	output logic [`SD_LBA_W-1:0] sd_lba,
	output logic                 last_sector
);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			sd_lba <= '0;
		else if (cnt_clear)
			sd_lba <= '0;
		else if (cnt_step)
			sd_lba <= sd_lba + 1'd1;
	end

	// Top sector of the backup image
	assign last_sector = &sd_lba[`BK_SECTORS_LOG2-1:0];

endmodule

//--- logic/bram_sequencer.sv
//////////////////////////////////////////////////
// Backup RAM load/save sequencing with the host
// One read or write request per sector
//////////////////////////////////////////////////
`timescale 1ns/10ps

module bram_sequencer (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_active,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        svp_quirk,
	input  logic        bk_load_cmd,
	input  logic        bk_save_cmd,
	input  logic        sd_ack,
	input  logic        last_sector,
	output logic        cnt_clear,
	output logic        cnt_step,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        bk_ena
);
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_ACK  = 2'd2;   // Wait for acknowledge to end

	logic [1:0] state;
	logic       dl_active_d, load_d, save_d, ack_d;
	logic       load_start, save_start;      // Registered start events
	wire        ack_rise = sd_ack & ~ack_d;
	wire        ack_fall = ~sd_ack & ack_d;

	assign cnt_clear = (state == ST_IDLE) & (load_start | save_start);
	assign cnt_step  = (state == ST_ACK) & ack_fall & ~last_sector;
	assign bk_busy   = state != ST_IDLE;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{dl_active_d, load_d, save_d, ack_d} <= '0;
			{load_start, save_start} <= '0;
			bk_ena <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			load_d      <= bk_load_cmd;
			save_d      <= bk_save_cmd;
			ack_d       <= sd_ack;
			// Load wins over save, download end always loads
			load_start  <= bk_ena & ((bk_load_cmd & ~load_d) | (~dl_active & dl_active_d & |img_size));
			save_start  <= bk_ena & bk_save_cmd & ~save_d;
			if (dl_active & ~dl_active_d)
				bk_ena <= 1'b0;
			if (dl_active & img_mounted & ~img_readonly & ~svp_quirk)
				bk_ena <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Sector FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= ST_IDLE;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (load_start | save_start) begin
					state      <= ST_REQ;
					bk_loading <= load_start;
					sd_rd      <= load_start;
					sd_wr      <= ~load_start;
				end
				ST_REQ: if (ack_rise) begin
					sd_rd <= 1'b0;   // Host has taken the request
					sd_wr <= 1'b0;
					state <= ST_ACK;
				end
				ST_ACK: if (ack_fall) begin
					if (last_sector) begin
						state      <= ST_IDLE;
						bk_loading <= 1'b0;
					end else begin
						state <= ST_REQ;
						sd_rd <= bk_loading;
						sd_wr <= ~bk_loading;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (RESET) !(sd_rd && sd_wr));

endmodule

//--- logic/cart_ctrl_top.sv
//////////////////////////////////////////////////
// Cartridge-load controller top level
// Region pick, quirk lookup and backup RAM transfers
//////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cart_params.svh"

module cart_ctrl_top (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       dl_active,
	input  logic                       dl_wr,
	input  logic [`CART_DL_ADDR_W-1:0] dl_addr,
	input  cart_pkg::dl_word_u         dl_data,
	input  logic [7:0]                 dl_index,
	input  logic                       reg_auto_off,
	input  logic                       reg_from_hdr,
	input  logic [1:0]                 reg_prio,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic [63:0]                img_size,
	input  logic                       bk_load_cmd,
	input  logic                       bk_save_cmd,
	input  logic                       sd_ack,
	output cart_pkg::region_e          region_req,
	output logic                       region_set,
	output logic                       sram_quirk,
	output logic                       eeprom_quirk,
	output logic                       svp_quirk,
	output logic                       fmbusy_quirk,
	output logic [`SD_LBA_W-1:0]       sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_ena
);
	logic hdr_j, hdr_u, hdr_e, hdr_ready;
	logic cnt_clear, cnt_step, last_sector;

	cart_region_scan u_scan (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.hdr_j     (hdr_j),
		.hdr_u     (hdr_u),
		.hdr_e     (hdr_e),
		.hdr_ready (hdr_ready)
	);

	cart_quirk_table u_quirk (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.sram_quirk   (sram_quirk),
		.eeprom_quirk (eeprom_quirk),
		.svp_quirk    (svp_quirk),
		.fmbusy_quirk (fmbusy_quirk)
	);

	region_select u_region (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.hdr_j        (hdr_j),
		.hdr_u        (hdr_u),
		.hdr_e        (hdr_e),
		.hdr_ready    (hdr_ready),
		.reg_auto_off (reg_auto_off),
		.reg_from_hdr (reg_from_hdr),
		.reg_prio     (reg_prio),
		.dl_index     (dl_index),
		.region_req   (region_req),
		.region_set   (region_set)
	);

	//////////////////////////////////////////////////
	// Backup RAM
	//////////////////////////////////////////////////
	bram_sector_count u_count (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cnt_clear   (cnt_clear),
		.cnt_step    (cnt_step),
		.sd_lba      (sd_lba),
		.last_sector (last_sector)
	);

	bram_sequencer u_seq (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active    (dl_active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.svp_quirk    (svp_quirk),   // SVP carts keep no backup
		.bk_load_cmd  (bk_load_cmd),
		.bk_save_cmd  (bk_save_cmd),
		.sd_ack       (sd_ack),
		.last_sector  (last_sector),
		.cnt_clear    (cnt_clear),
		.cnt_step     (cnt_step),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_ena       (bk_ena)
	);

endmodule

//--- verif/tb_clock.sv
//////////////////////////////////////////////////
// Testbench clock (40 ns) and reset for 5 cycles
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_clock (
	output logic clk_sys,
	output logic RESET
);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		RESET = 1'b1;
		repeat (5) @(posedge clk_sys);
		RESET <= 1'b0;
	end

endmodule

//--- verif/tb_checker.sv
//////////////////////////////////////////////////
// Reference model and comparisons for the DUT
// Samples everything on the falling clock edge
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_checker (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_active,
	input  logic        dl_wr,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	input  logic [7:0]  dl_index,
	input  logic        reg_auto_off,
	input  logic        reg_from_hdr,
	input  logic [1:0]  reg_prio,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        bk_load_cmd,
	input  logic        bk_save_cmd,
	input  logic [1:0]  region_req,
	input  logic        region_set,
	input  logic        sram_quirk,
	input  logic        eeprom_quirk,
	input  logic        svp_quirk,
	input  logic        fmbusy_quirk,
	input  logic [31:0] sd_lba,
	input  logic        sd_rd,
	input  logic        sd_wr,
	input  logic        bk_busy,
	input  logic        bk_loading,
	input  logic        bk_ena,
	output int          mism_cnt,
	output int          other_cnt,
	output logic        exp_bk_ena
);
	logic        act_d, load_d, save_d, req_d, busy_d;
	logic [2:0]  letters;       // {J, U, EU} seen in this header
	logic [63:0] serial;
	logic [3:0]  exp_quirk;     // {sram, eeprom, svp, fmbusy}
	logic [1:0]  exp_req;
	logic        exp_set, chk_req, exp_load, ena_cond;
	int          pend, sec_cnt;
	wire         wr = dl_active & dl_wr;

	function automatic logic [2:0] letter_code(input logic [7:0] c);
		if (c == "J")
			return 3'b100;
		if (c == "U")
			return 3'b010;
		if (c >= 8'h30 && c <= 8'h5A)
			return 3'b001;
		return 3'b000;
	endfunction

	function automatic logic [3:0] quirk_of(input logic [63:0] s);
		if (s == "T-081276" || s == "T-81406 ")
			return 4'b1000;
		if (s == "MK-1215 " || s == "G-4060  ")
			return 4'b0100;
		if (s == "MK-1229 " || s == "G-7001  ")
			return 4'b0010;
		if (s == "T-35036 ")
			return 4'b0001;
		return 4'b0000;
	endfunction

	// Region codes JP=0 US=1 EU=2 with the first choice in the top bits
	function automatic logic [1:0] pick_region(input logic [2:0] l, input logic [1:0] prio);
		logic [5:0] order;
		logic [1:0] code;
		case (prio)
			2'd0:    order = {2'd1, 2'd2, 2'd0};
			2'd1:    order = {2'd2, 2'd1, 2'd0};
			2'd2:    order = {2'd1, 2'd0, 2'd2};
			default: order = {2'd0, 2'd1, 2'd2};
		endcase
		for (int i = 0; i < 3; i++) begin
			code = order[5 - 2 * i -: 2];
			if ((code == 2'd0 && l[2]) || (code == 2'd1 && l[1]) || (code == 2'd2 && l[0]))
				return code;
		end
		return order[5:4];   // Nothing found
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
		if (exp !== got) begin
			mism_cnt++;
			$display("MISMATCH t=%0t %s expected=%0h got=%0h", $time, name, exp, got);
		end
	endtask

	task automatic report_other(input string msg);
		other_cnt++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	initial begin
		mism_cnt = 0;
		other_cnt = 0;
	end

	always @(negedge clk_sys) begin
		if (RESET) begin
			{act_d, load_d, save_d, req_d, busy_d} = '0;
			letters = '0;
			exp_quirk = '0;
			exp_bk_ena = 1'b0;
			exp_load = 1'b0;
			pend = 0;
			sec_cnt = 0;
		end else begin
			check_val("quirk_flags", exp_quirk, {sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk});
			check_val("bk_ena", exp_bk_ena, bk_ena);
			if (pend > 0) begin
				pend--;
				if (pend == 0) begin
					check_val("region_set", exp_set, region_set);
					if (chk_req)
						check_val("region_req", exp_req, region_req);
				end
			end

			//////////////////////////////////////////////////
			// Next state of the model
			//////////////////////////////////////////////////
			ena_cond = dl_active & img_mounted & ~img_readonly & ~exp_quirk[1];   // Old svp
			if (dl_active & ~act_d) begin
				letters = '0;
				exp_quirk = '0;
				exp_bk_ena = 1'b0;
			end
			if (wr) begin
				case (dl_addr)
					25'h182: serial[63:56] = dl_data[15:8];
					25'h184: serial[55:40] = {dl_data[7:0], dl_data[15:8]};
					25'h186: serial[39:24] = {dl_data[7:0], dl_data[15:8]};
					25'h188: serial[23:8]  = {dl_data[7:0], dl_data[15:8]};
					25'h18A: serial[7:0]   = dl_data[7:0];
					25'h18C: exp_quirk = exp_quirk | quirk_of(serial);
					25'h1F0: letters = letters | letter_code(dl_data[7:0]) | letter_code(dl_data[15:8]);
					25'h1F2: letters = letters | letter_code(dl_data[7:0]);
					25'h200: begin
						pend = 2;
						chk_req = ~reg_auto_off;
						if (reg_auto_off)
							exp_set = 1'b0;
						else if (reg_from_hdr) begin
							exp_req = pick_region(letters, reg_prio);
							exp_set = 1'b1;
						end else begin
							exp_req = dl_index[7:6];
							exp_set = |dl_index;
						end
					end
					default: ;
				endcase
			end
			if (ena_cond)
				exp_bk_ena = 1'b1;

			// Transfer direction follows the last start event
			if (~bk_busy) begin
				if ((bk_load_cmd & ~load_d) | (~dl_active & act_d))
					exp_load = 1'b1;
				else if (bk_save_cmd & ~save_d)
					exp_load = 1'b0;
			end
			if ((sd_rd | sd_wr) & ~req_d) begin
				check_val("sd_lba", sec_cnt, sd_lba);
				check_val("sd_rd", exp_load, sd_rd);
				check_val("sd_wr", !exp_load, sd_wr);
				check_val("bk_loading", exp_load, bk_loading);
				sec_cnt++;
			end
			if (busy_d & ~bk_busy) begin
				if (sec_cnt != 128)
					report_other($sformatf("sequence ended after %0d sectors instead of 128", sec_cnt));
				check_val("bk_loading", 0, bk_loading);
				sec_cnt = 0;
			end
			{act_d, load_d, save_d, req_d, busy_d} =
				{dl_active, bk_load_cmd, bk_save_cmd, sd_rd | sd_wr, bk_busy};
		end
	end

endmodule

//--- verif/tb_top.sv
//////////////////////////////////////////////////
// Testbench top with random downloads and a host model
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_top;
	logic        clk_sys, RESET;
	logic        dl_active, dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [7:0]  dl_index;
	logic        reg_auto_off, reg_from_hdr;
	logic [1:0]  reg_prio;
	logic        img_mounted, img_readonly;
	logic [63:0] img_size;
	logic        bk_load_cmd, bk_save_cmd;
	logic        sd_ack = 1'b0;
	wire  [1:0]  region_req;
	wire  [31:0] sd_lba;
	wire         region_set, sram_quirk, eeprom_quirk, svp_quirk, fmbusy_quirk;
	wire         sd_rd, sd_wr, bk_busy, bk_loading, bk_ena;
	int          mism_cnt, other_cnt, fault_cnt;
	logic        exp_bk_ena;

	logic [31:0] lfsr = 32'h85aa;
	logic [1:0]  host_state;
	logic [2:0]  host_cnt;
	logic [63:0] serials [8];
	logic [63:0] serial;
	logic [1:0]  mode;
	int          n;

	tb_clock u_clk (.clk_sys(clk_sys), .RESET(RESET));

	cart_ctrl_top u_dut (.*);

	tb_checker u_chk (.*);

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] pick_letter();
		case (rand_bits(3))
			0: return "J";
			1: return "U";
			2: return "E";
			3: return "A";
			4: return "4";
			5: return " ";
			6: return "a";   // Outside the region range
			default: return "B";
		endcase
	endfunction

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
	endtask

	// Header words placed where the serial and region fields live
	task automatic run_download(input logic [63:0] s, input logic [15:0] ra, input logic [15:0] rb);
		logic [15:0] d;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		for (int a = 0; a <= 'h210; a += 2) begin
			d = rand_bits(16);
			case (a)
				'h182: d = {s[63:56], d[7:0]};
				'h184: d = {s[47:40], s[55:48]};
				'h186: d = {s[31:24], s[39:32]};
				'h188: d = {s[15:8], s[23:16]};
				'h18A: d = {d[15:8], s[7:0]};
				'h1F0: d = ra;
				'h1F2: d = rb;
				default: ;
			endcase
			write_word(a, d);
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		dl_wr     <= 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int cnt;
		cnt = 0;
		@(negedge clk_sys);
		while (bk_busy !== level && cnt < limit) begin
			@(negedge clk_sys);
			cnt++;
		end
		if (bk_busy !== level) begin
			fault_cnt++;
			$display("ERROR t=%0t timed out waiting for bk_busy to become %0d", $time, level);
		end
		@(posedge clk_sys);
	endtask

	// Watches a window in which no transfer may begin
	task automatic expect_no_transfer(input int cycles, input string what);
		logic seen;
		seen = 1'b0;
		repeat (cycles) begin
			@(negedge clk_sys);
			seen = seen | bk_busy | sd_rd | sd_wr;
		end
		if (seen) begin
			fault_cnt++;
			$display("ERROR t=%0t %s started a transfer that should not happen", $time, what);
		end
		@(posedge clk_sys);
	endtask

	// One load or save command and the transfer it should start
	task automatic issue_command(input logic load);
		@(posedge clk_sys);
		if (load)
			bk_load_cmd <= 1'b1;
		else
			bk_save_cmd <= 1'b1;
		if (exp_bk_ena) begin
			wait_busy(1'b1, 10);
			wait_busy(1'b0, 5000);
		end else
			expect_no_transfer(12, load ? "load command" : "save command");
		bk_load_cmd <= 1'b0;
		bk_save_cmd <= 1'b0;
	endtask

	// Host model with a random delay before the acknowledge and a random hold
	always @(posedge clk_sys) begin
		if (RESET) begin
			host_state <= 2'd0;
			host_cnt   <= '0;
			sd_ack     <= 1'b0;
		end else begin
			case (host_state)
				2'd0: if (sd_rd | sd_wr) begin
					host_cnt   <= rand_bits(3);
					host_state <= 2'd1;
				end
				2'd1: if (host_cnt == 0) begin
					sd_ack     <= 1'b1;
					host_cnt   <= rand_bits(3);
					host_state <= 2'd2;
				end else
					host_cnt <= host_cnt - 1'd1;
				default: if (host_cnt == 0) begin
					sd_ack     <= 1'b0;
					host_state <= 2'd0;
				end else
					host_cnt <= host_cnt - 1'd1;
			endcase
		end
	end

	initial begin
		{dl_active, dl_wr, dl_addr, dl_data, dl_index} = '0;
		{reg_auto_off, reg_from_hdr, reg_prio} = '0;
		{img_mounted, img_readonly, img_size} = '0;
		{bk_load_cmd, bk_save_cmd} = '0;
		fault_cnt = 0;
		serials = '{"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ",
			"MK-1229 ", "G-7001  ", "T-35036 ", "NOT-LIST"};

		n = 0;
		while (RESET !== 1'b0 && n < 50) begin
			@(negedge clk_sys);
			n++;
		end
		if (RESET !== 1'b0) begin
			fault_cnt++;
			$display("ERROR t=%0t reset was never released", $time);
		end

		for (int d = 0; d < 12; d++) begin
			@(posedge clk_sys);
			mode = rand_bits(2);
			reg_from_hdr <= mode < 2;
			reg_auto_off <= mode == 3;
			reg_prio     <= rand_bits(2);
			dl_index     <= rand_bits(8);
			img_mounted  <= rand_bits(2) != 0;
			img_readonly <= rand_bits(2) == 0;
			img_size     <= (rand_bits(2) != 0) ? 64'h2000 : 64'h0;
			serial = rand_bits(1) ? serials[rand_bits(3)] : {rand_bits(32), rand_bits(32)};
			run_download(serial, {pick_letter(), pick_letter()}, {rand_bits(8), pick_letter()});
			repeat (2) @(posedge clk_sys);

			// Download end loads only when enabled and the image has a size
			if (exp_bk_ena && img_size != 0) begin
				wait_busy(1'b1, 10);
				wait_busy(1'b0, 5000);
			end else
				expect_no_transfer(12, "download end");
			issue_command(1'b0);
			issue_command(1'b1);
		end

		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d mismatches, %0d other", mism_cnt, other_cnt + fault_cnt);
		if (mism_cnt + other_cnt + fault_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- gen_cart_ctrl.f
+incdir+logic
logic/cart_pkg.sv
logic/cart_region_scan.sv
logic/cart_quirk_table.sv
logic/region_select.sv
logic/bram_sector_count.sv
logic/bram_sequencer.sv
logic/cart_ctrl_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Makefile
# Verilator build and run for the cartridge-load controller

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= gen_cart_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module cart_ctrl_top -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
